// ==== axi_pkg.sv ====
`default_nettype none

package axi_pkg;

	// bresp / rresp encodings, exokay and decerr never produced here
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

	// axsize, bytes per beat as log2
	typedef enum logic [2:0] {
		SIZE_1 = 3'b000,
		SIZE_2 = 3'b001,
		SIZE_4 = 3'b010
	} axi_size_e;

endpackage

`default_nettype wire

// ==== lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int REG_W  = 5;

	// bit 3 set for stores, low bits follow rv32 funct3
	typedef enum logic [3:0] {
		LB  = 4'h0,
		LH  = 4'h1,
		LW  = 4'h2,
		LBU = 4'h4,
		LHU = 4'h5,
		SB  = 4'h8,
		SH  = 4'h9,
		SW  = 4'ha
	} lsu_op_e;

	function automatic logic op_is_store(input lsu_op_e op);
		return op inside {SB, SH, SW};
	endfunction

	function automatic logic op_is_half(input lsu_op_e op);
		return op inside {LH, LHU, SH};
	endfunction

	function automatic logic op_is_word(input lsu_op_e op);
		return op inside {LW, SW};
	endfunction

endpackage

`default_nettype wire

// ==== lsu_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_align (
	input  lsu_pkg::lsu_op_e             op_i,
	input  logic [1:0]                   addr_lsb_i,
	input  logic [lsu_pkg::DATA_W-1:0]   wdata_i,
	input  logic [lsu_pkg::DATA_W-1:0]   rdata_i,
	output logic [lsu_pkg::DATA_W-1:0]   wdata_lane_o,
	output logic [lsu_pkg::STRB_W-1:0]   wstrb_o,
	output axi_pkg::axi_size_e           size_o,
	output logic                         misalign_o,
	output logic [lsu_pkg::DATA_W-1:0]   load_result_o
);
	import lsu_pkg::*;
	import axi_pkg::*;

	logic [DATA_W-1:0] rd_lane;

	// access size and natural alignment check
	always_comb begin
		if (op_is_word(op_i)) begin
			size_o = SIZE_4;
		end else if (op_is_half(op_i)) begin
			size_o = SIZE_2;
		end else begin
			size_o = SIZE_1;
		end
		// halfword on odd byte, word off a word boundary
		misalign_o = (op_is_half(op_i) && addr_lsb_i[0]) ||
			(op_is_word(op_i) && (addr_lsb_i != 2'b00));
	end

	// store data replicated so every lane holds the value
	always_comb begin
		case (op_i)
			SB: begin
				wdata_lane_o = {STRB_W{wdata_i[7:0]}};
				wstrb_o      = STRB_W'(1) << addr_lsb_i;
			end
			SH: begin
				wdata_lane_o = {(STRB_W / 2){wdata_i[15:0]}};
				// upper or lower half picked by addr bit 1
				wstrb_o      = STRB_W'(2'b11) << {addr_lsb_i[1], 1'b0};
			end
			SW: begin
				wdata_lane_o = wdata_i;
				wstrb_o      = '1;
			end
			default: begin
				// loads write nothing
				wdata_lane_o = '0;
				wstrb_o      = '0;
			end
		endcase
	end

	// addressed byte of the read word moved down to bit 0
	assign rd_lane = rdata_i >> {addr_lsb_i, 3'b000};

	always_comb begin
		case (op_i)
			LB:      load_result_o = {{(DATA_W - 8){rd_lane[7]}}, rd_lane[7:0]};
			LBU:     load_result_o = {{(DATA_W - 8){1'b0}}, rd_lane[7:0]};
			LH:      load_result_o = {{(DATA_W - 16){rd_lane[15]}}, rd_lane[15:0]};
			LHU:     load_result_o = {{(DATA_W - 16){1'b0}}, rd_lane[15:0]};
			LW:      load_result_o = rdata_i;
			default: load_result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== lsu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl #(
	parameter int ADDR_W = 32
) (
	input  logic                         clock,
	input  logic                         rstn,
	// request from execute
	input  logic                         req_valid_i,
	output logic                         req_ready_o,
	input  lsu_pkg::lsu_op_e             req_op_i,
	input  logic [ADDR_W-1:0]            req_addr_i,
	input  logic [lsu_pkg::DATA_W-1:0]   req_wdata_i,
	input  logic [lsu_pkg::REG_W-1:0]    req_rd_i,
	// completion
	output logic                         resp_valid_o,
	output logic [lsu_pkg::DATA_W-1:0]   resp_rdata_o,
	output logic [lsu_pkg::REG_W-1:0]    resp_rd_o,
	output logic                         resp_err_o,
	// axi4-lite master
	output logic [ADDR_W-1:0]            awaddr_o,
	output axi_pkg::axi_size_e           awsize_o,
	output logic                         awvalid_o,
	input  logic                         awready_i,
	output logic [lsu_pkg::DATA_W-1:0]   wdata_o,
	output logic [lsu_pkg::STRB_W-1:0]   wstrb_o,
	output logic                         wvalid_o,
	input  logic                         wready_i,
	input  axi_pkg::axi_resp_e           bresp_i,
	input  logic                         bvalid_i,
	output logic                         bready_o,
	output logic [ADDR_W-1:0]            araddr_o,
	output axi_pkg::axi_size_e           arsize_o,
	output logic                         arvalid_o,
	input  logic                         arready_i,
	input  logic [lsu_pkg::DATA_W-1:0]   rdata_i,
	input  axi_pkg::axi_resp_e           rresp_i,
	input  logic                         rvalid_i,
	output logic                         rready_o,
	// aligner
	output lsu_pkg::lsu_op_e             op_o,
	output logic [1:0]                   addr_o,
	output logic [lsu_pkg::DATA_W-1:0]   wdata_raw_o,
	output logic [lsu_pkg::DATA_W-1:0]   rdata_raw_o,
	input  logic [lsu_pkg::DATA_W-1:0]   wdata_lane_i,
	input  logic [lsu_pkg::STRB_W-1:0]   wstrb_i,
	input  axi_pkg::axi_size_e           size_i,
	input  logic                         misalign_i,
	input  logic [lsu_pkg::DATA_W-1:0]   load_result_i
);
	import lsu_pkg::*;
	import axi_pkg::*;

	typedef enum logic [1:0] {IDLE, ADDR, RESP, DONE} state_e;

	state_e            state_q, state_d;
	lsu_op_e           op_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [DATA_W-1:0] rdata_q;
	logic [REG_W-1:0]  rd_q;
	logic              aw_done_q, w_done_q, err_q;
	logic              is_store;
	logic              req_hs, aw_hs, w_hs, ar_hs, b_hs, r_hs;
	logic              wr_sent;

	assign is_store = op_is_store(op_q);

	assign req_ready_o = (state_q == IDLE);
	assign req_hs      = req_valid_i & req_ready_o;

	// misaligned requests never reach the bus
	assign awvalid_o = (state_q == ADDR) && is_store && !misalign_i && !aw_done_q;
	assign wvalid_o  = (state_q == ADDR) && is_store && !misalign_i && !w_done_q;
	assign arvalid_o = (state_q == ADDR) && !is_store && !misalign_i;
	assign bready_o  = (state_q == RESP) && is_store;
	assign rready_o  = (state_q == RESP) && !is_store;

	assign aw_hs = awvalid_o & awready_i;
	assign w_hs  = wvalid_o & wready_i;
	assign ar_hs = arvalid_o & arready_i;
	assign b_hs  = bvalid_i & bready_o;
	assign r_hs  = rvalid_i & rready_o;

	// aw and w may land in different cycles
	assign wr_sent = (aw_done_q | aw_hs) & (w_done_q | w_hs);

	// payload straight from latched request and aligner
	assign awaddr_o    = addr_q;
	assign araddr_o    = addr_q;
	assign awsize_o    = size_i;
	assign arsize_o    = size_i;
	assign wdata_o     = wdata_lane_i;
	assign wstrb_o     = wstrb_i;
	assign op_o        = op_q;
	assign addr_o      = addr_q[1:0];
	assign wdata_raw_o = wdata_q;
	assign rdata_raw_o = rdata_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (req_hs) begin
					state_d = ADDR;
				end
			end
			ADDR: begin
				if (misalign_i) begin
					state_d = DONE;
				end else if (is_store ? wr_sent : ar_hs) begin
					state_d = RESP;
				end
			end
			RESP: begin
				if (is_store ? b_hs : r_hs) begin
					state_d = DONE;
				end
			end
			default: begin
				// single done pulse then back to idle
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q   <= IDLE;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			state_q <= state_d;
			if (req_hs) begin
				aw_done_q <= 1'b0;
				w_done_q  <= 1'b0;
				err_q     <= 1'b0;
			end else begin
				if (aw_hs) begin
					aw_done_q <= 1'b1;
				end
				if (w_hs) begin
					w_done_q <= 1'b1;
				end
				if ((state_q == ADDR) && misalign_i) begin
					err_q <= 1'b1;
				end
				if (b_hs) begin
					err_q <= (bresp_i == SLVERR);
				end
				if (r_hs) begin
					err_q <= (rresp_i == SLVERR);
				end
			end
		end
	end

	// request fields and read word
	always_ff @(posedge clock) begin
		if (req_hs) begin
			op_q    <= req_op_i;
			addr_q  <= req_addr_i;
			wdata_q <= req_wdata_i;
			rd_q    <= req_rd_i;
		end
		if (r_hs) begin
			rdata_q <= rdata_i;
		end
	end

	assign resp_valid_o = (state_q == DONE);
	// stores and failed accesses report zero
	assign resp_rdata_o = (is_store || err_q) ? '0 : load_result_i;
	assign resp_rd_o    = rd_q;
	assign resp_err_o   = err_q;

	// valid and payload held until the slave takes them
	a_aw_hold: assert property (@(posedge clock) disable iff (!rstn)
		(awvalid_o && !awready_i) |=> (awvalid_o && $stable(awaddr_o)));
	a_w_hold: assert property (@(posedge clock) disable iff (!rstn)
		(wvalid_o && !wready_i) |=> (wvalid_o && $stable(wdata_o) && $stable(wstrb_o)));
	a_ar_hold: assert property (@(posedge clock) disable iff (!rstn)
		(arvalid_o && !arready_i) |=> (arvalid_o && $stable(araddr_o)));

endmodule

`default_nettype wire

// ==== axi_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_sram #(
	parameter int              ADDR_W    = 32,
	parameter int              MEM_WORDS = 256,
	parameter logic [ADDR_W-1:0] BASE_ADDR = 32'h8000_0000
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic [ADDR_W-1:0]            awaddr_i,
	input  axi_pkg::axi_size_e           awsize_i,
	input  logic                         awvalid_i,
	output logic                         awready_o,
	input  logic [lsu_pkg::DATA_W-1:0]   wdata_i,
	input  logic [lsu_pkg::STRB_W-1:0]   wstrb_i,
	input  logic                         wvalid_i,
	output logic                         wready_o,
	output axi_pkg::axi_resp_e           bresp_o,
	output logic                         bvalid_o,
	input  logic                         bready_i,
	input  logic [ADDR_W-1:0]            araddr_i,
	input  axi_pkg::axi_size_e           arsize_i,
	input  logic                         arvalid_i,
	output logic                         arready_o,
	output logic [lsu_pkg::DATA_W-1:0]   rdata_o,
	output axi_pkg::axi_resp_e           rresp_o,
	output logic                         rvalid_o,
	input  logic                         rready_i
);
	import lsu_pkg::*;
	import axi_pkg::*;

	localparam int                IDX_W     = $clog2(MEM_WORDS);
	localparam logic [ADDR_W-1:0] MEM_BYTES = ADDR_W'(MEM_WORDS * 4);

	logic [DATA_W-1:0] mem [MEM_WORDS];

	logic              aw_got_q, w_got_q, bvalid_q, rvalid_q;
	logic [ADDR_W-1:0] aw_addr_q;
	axi_size_e         aw_size_q;
	logic [DATA_W-1:0] w_data_q, rdata_q;
	logic [STRB_W-1:0] w_strb_q;
	axi_resp_e         bresp_q, rresp_q;
	logic              aw_hs, w_hs, ar_hs, wr_go, wr_ok, rd_ok;
	logic [ADDR_W-1:0] wr_addr;
	axi_size_e         wr_size;
	logic [DATA_W-1:0] wr_data;
	logic [STRB_W-1:0] wr_strb;
	logic [IDX_W-1:0]  wr_idx, rd_idx;

	// inside the window and naturally aligned for its size
	function automatic logic addr_ok(input logic [ADDR_W-1:0] addr, input axi_size_e size);
		logic aligned;
		case (size)
			SIZE_1:  aligned = 1'b1;
			SIZE_2:  aligned = ~addr[0];
			SIZE_4:  aligned = (addr[1:0] == 2'b00);
			default: aligned = 1'b0;
		endcase
		return aligned && (addr >= BASE_ADDR) && ((addr - BASE_ADDR) < MEM_BYTES);
	endfunction

	// one address and one data beat held at a time
	assign awready_o = !bvalid_q && !aw_got_q;
	assign wready_o  = !bvalid_q && !w_got_q;
	assign arready_o = !rvalid_q;

	assign aw_hs = awvalid_i & awready_o;
	assign w_hs  = wvalid_i & wready_o;
	assign ar_hs = arvalid_i & arready_o;

	// write fires once both halves are in, from capture or live bus
	assign wr_go   = (aw_got_q | aw_hs) & (w_got_q | w_hs);
	assign wr_addr = aw_got_q ? aw_addr_q : awaddr_i;
	assign wr_size = aw_got_q ? aw_size_q : awsize_i;
	assign wr_data = w_got_q ? w_data_q : wdata_i;
	assign wr_strb = w_got_q ? w_strb_q : wstrb_i;
	assign wr_ok   = addr_ok(wr_addr, wr_size);
	assign rd_ok   = addr_ok(araddr_i, arsize_i);
	// word offset from the base
	assign wr_idx  = IDX_W'((wr_addr - BASE_ADDR) >> 2);
	assign rd_idx  = IDX_W'((araddr_i - BASE_ADDR) >> 2);

	always_ff @(posedge clock) begin
		if (!rstn) begin
			aw_got_q <= 1'b0;
			w_got_q  <= 1'b0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_go) begin
				aw_got_q <= 1'b0;
				w_got_q  <= 1'b0;
				bvalid_q <= 1'b1;
			end else begin
				if (aw_hs) begin
					aw_got_q <= 1'b1;
				end
				if (w_hs) begin
					w_got_q <= 1'b1;
				end
				if (bvalid_q && bready_i) begin
					bvalid_q <= 1'b0;
				end
			end
			if (ar_hs) begin
				rvalid_q <= 1'b1;
			end else if (rvalid_q && rready_i) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	// captures, array and response payload
	always_ff @(posedge clock) begin
		if (aw_hs) begin
			aw_addr_q <= awaddr_i;
			aw_size_q <= awsize_i;
		end
		if (w_hs) begin
			w_data_q <= wdata_i;
			w_strb_q <= wstrb_i;
		end
		if (wr_go) begin
			bresp_q <= wr_ok ? OKAY : SLVERR;
			// only strobed bytes change
			for (int b = 0; b < STRB_W; b++) begin
				if (wr_ok && wr_strb[b]) begin
					mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
		if (ar_hs) begin
			rresp_q <= rd_ok ? OKAY : SLVERR;
			rdata_q <= rd_ok ? mem[rd_idx] : '0;
		end
	end

	assign bvalid_o = bvalid_q;
	assign bresp_o  = bresp_q;
	assign rvalid_o = rvalid_q;
	assign rresp_o  = rresp_q;
	assign rdata_o  = rdata_q;

	// responses wait for the master
	a_b_hold: assert property (@(posedge clock) disable iff (!rstn)
		(bvalid_o && !bready_i) |=> (bvalid_o && $stable(bresp_o)));
	a_r_hold: assert property (@(posedge clock) disable iff (!rstn)
		(rvalid_o && !rready_i) |=> (rvalid_o && $stable(rdata_o) && $stable(rresp_o)));

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
	parameter int                ADDR_W    = 32,
	parameter int                MEM_WORDS = 256,
	parameter logic [ADDR_W-1:0] BASE_ADDR = 32'h8000_0000
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         req_valid_i,
	output logic                         req_ready_o,
	input  lsu_pkg::lsu_op_e             req_op_i,
	input  logic [ADDR_W-1:0]            req_addr_i,
	input  logic [lsu_pkg::DATA_W-1:0]   req_wdata_i,
	input  logic [lsu_pkg::REG_W-1:0]    req_rd_i,
	output logic                         resp_valid_o,
	output logic [lsu_pkg::DATA_W-1:0]   resp_rdata_o,
	output logic [lsu_pkg::REG_W-1:0]    resp_rd_o,
	output logic                         resp_err_o
);
	import lsu_pkg::*;
	import axi_pkg::*;

	// axi4-lite between controller and memory
	logic [ADDR_W-1:0] awaddr, araddr;
	axi_size_e         awsize, arsize;
	logic              awvalid, awready, wvalid, wready, bvalid, bready;
	logic              arvalid, arready, rvalid, rready;
	logic [DATA_W-1:0] wdata, rdata;
	logic [STRB_W-1:0] wstrb;
	axi_resp_e         bresp, rresp;

	// controller to aligner and back
	lsu_op_e           al_op;
	logic [1:0]        al_addr;
	logic [DATA_W-1:0] al_wdata_raw, al_rdata_raw, al_wdata_lane, al_load_result;
	logic [STRB_W-1:0] al_wstrb;
	axi_size_e         al_size;
	logic              al_misalign;

	lsu_ctrl #(
		.ADDR_W (ADDR_W)
	) u_ctrl (
		.clock         (clock),
		.rstn          (rstn),
		.req_valid_i   (req_valid_i),
		.req_ready_o   (req_ready_o),
		.req_op_i      (req_op_i),
		.req_addr_i    (req_addr_i),
		.req_wdata_i   (req_wdata_i),
		.req_rd_i      (req_rd_i),
		.resp_valid_o  (resp_valid_o),
		.resp_rdata_o  (resp_rdata_o),
		.resp_rd_o     (resp_rd_o),
		.resp_err_o    (resp_err_o),
		.awaddr_o      (awaddr),
		.awsize_o      (awsize),
		.awvalid_o     (awvalid),
		.awready_i     (awready),
		.wdata_o       (wdata),
		.wstrb_o       (wstrb),
		.wvalid_o      (wvalid),
		.wready_i      (wready),
		.bresp_i       (bresp),
		.bvalid_i      (bvalid),
		.bready_o      (bready),
		.araddr_o      (araddr),
		.arsize_o      (arsize),
		.arvalid_o     (arvalid),
		.arready_i     (arready),
		.rdata_i       (rdata),
		.rresp_i       (rresp),
		.rvalid_i      (rvalid),
		.rready_o      (rready),
		.op_o          (al_op),
		.addr_o        (al_addr),
		.wdata_raw_o   (al_wdata_raw),
		.rdata_raw_o   (al_rdata_raw),
		.wdata_lane_i  (al_wdata_lane),
		.wstrb_i       (al_wstrb),
		.size_i        (al_size),
		.misalign_i    (al_misalign),
		.load_result_i (al_load_result)
	);

	lsu_align u_align (
		.op_i          (al_op),
		.addr_lsb_i    (al_addr),
		.wdata_i       (al_wdata_raw),
		.rdata_i       (al_rdata_raw),
		.wdata_lane_o  (al_wdata_lane),
		.wstrb_o       (al_wstrb),
		.size_o        (al_size),
		.misalign_o    (al_misalign),
		.load_result_o (al_load_result)
	);

	axi_sram #(
		.ADDR_W    (ADDR_W),
		.MEM_WORDS (MEM_WORDS),
		.BASE_ADDR (BASE_ADDR)
	) u_sram (
		.clock     (clock),
		.rstn      (rstn),
		.awaddr_i  (awaddr),
		.awsize_i  (awsize),
		.awvalid_i (awvalid),
		.awready_o (awready),
		.wdata_i   (wdata),
		.wstrb_i   (wstrb),
		.wvalid_i  (wvalid),
		.wready_o  (wready),
		.bresp_o   (bresp),
		.bvalid_o  (bvalid),
		.bready_i  (bready),
		.araddr_i  (araddr),
		.arsize_i  (arsize),
		.arvalid_i (arvalid),
		.arready_o (arready),
		.rdata_o   (rdata),
		.rresp_o   (rresp),
		.rvalid_o  (rvalid),
		.rready_i  (rready)
	);

endmodule

`default_nettype wire

// ==== tb_lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;
	import lsu_pkg::*;

	localparam int          ADDR_W     = 32;
	localparam int          MEM_WORDS  = 256;
	localparam logic [31:0] BASE_ADDR  = 32'h8000_0000;
	localparam logic [31:0] MEM_BYTES  = 32'(MEM_WORDS * 4);
	localparam int          POS_W      = $clog2(MEM_WORDS * 4);
	// requests issued by each test
	localparam int          N_WORDS    = 16;
	localparam int          N_LANE     = 4;
	localparam int          N_OOR      = 4;
	localparam int          N_REQ      = 2 * N_WORDS + 17 * N_LANE + 12 + 5 * N_OOR;
	localparam int          MAX_CYCLES = 8 * N_REQ + 100;

	logic              clock = 1'b0;
	logic              rstn;
	logic              req_valid;
	logic              req_ready;
	lsu_op_e           req_op;
	logic [ADDR_W-1:0] req_addr;
	logic [DATA_W-1:0] req_wdata;
	logic [REG_W-1:0]  req_rd;
	logic              resp_valid;
	logic [DATA_W-1:0] resp_rdata;
	logic [REG_W-1:0]  resp_rd;
	logic              resp_err;

	// byte image of the data memory
	logic [7:0]        shadow [MEM_WORDS * 4];
	logic [31:0]       lfsr_q = 32'h9f8670be;
	// expectation for the request in flight
	logic [DATA_W-1:0] exp_data;
	logic [REG_W-1:0]  exp_rd;
	logic              exp_err;
	int                accepted = 0;
	int                responded = 0;
	int                cycles = 0;
	int                data_errs = 0;
	int                rd_errs = 0;
	int                flag_errs = 0;
	int                proto_errs = 0;

	lsu_top #(
		.ADDR_W    (ADDR_W),
		.MEM_WORDS (MEM_WORDS),
		.BASE_ADDR (BASE_ADDR)
	) u_dut (
		.clock        (clock),
		.rstn         (rstn),
		.req_valid_i  (req_valid),
		.req_ready_o  (req_ready),
		.req_op_i     (req_op),
		.req_addr_i   (req_addr),
		.req_wdata_i  (req_wdata),
		.req_rd_i     (req_rd),
		.resp_valid_o (resp_valid),
		.resp_rdata_o (resp_rdata),
		.resp_rd_o    (resp_rd),
		.resp_err_o   (resp_err)
	);

	always #10 clock = ~clock;

	// pulse count and run limit
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (rstn && resp_valid) begin
			responded <= responded + 1;
		end
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, %0d of %0d requests answered",
				cycles, responded, accepted);
			$display("Simulation failed");
			$finish;
		end
	end

	// idle right out of reset
	a_reset_idle: assert property (@(posedge clock) $rose(rstn) |-> (req_ready && !resp_valid))
		else begin
			proto_errs++;
			$display("%0t: DUT not idle after reset release", $time);
		end

	// exactly one pulse per accepted request
	a_one_resp: assert property (@(posedge clock) disable iff (!rstn)
		resp_valid |-> (accepted == responded + 1))
		else begin
			proto_errs++;
			$display("%0t: completion pulse with no request outstanding", $time);
		end

	a_rdata: assert property (@(posedge clock) disable iff (!rstn)
		resp_valid |-> (resp_rdata == exp_data))
		else begin
			data_errs++;
			$display("[ERROR] %0t resp_rdata_o expected %h actual %h",
				$time, exp_data, $sampled(resp_rdata));
		end

	a_rd: assert property (@(posedge clock) disable iff (!rstn)
		resp_valid |-> (resp_rd == exp_rd))
		else begin
			rd_errs++;
			$display("[ERROR] %0t resp_rd_o expected %0d actual %0d",
				$time, exp_rd, $sampled(resp_rd));
		end

	a_err: assert property (@(posedge clock) disable iff (!rstn)
		resp_valid |-> (resp_err == exp_err))
		else begin
			flag_errs++;
			$display("[ERROR] %0t resp_err_o expected %b actual %b",
				$time, exp_err, $sampled(resp_err));
		end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val    = {val[30:0], fb};
		end
		return val;
	endfunction

	// byte level model, little endian lanes
	task automatic predict(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
		int               nbytes;
		logic             store;
		logic [31:0]      off;
		logic [31:0]      val;
		logic [POS_W-1:0] pos;
		case (op)
			LW, SW:      nbytes = 4;
			LH, LHU, SH: nbytes = 2;
			default:     nbytes = 1;
		endcase
		store    = (op == SB) || (op == SH) || (op == SW);
		exp_err  = ((addr & 32'(nbytes - 1)) != 32'd0) ||
			(addr < BASE_ADDR) || ((addr - BASE_ADDR) >= MEM_BYTES);
		exp_data = '0;
		val      = '0;
		off      = addr - BASE_ADDR;
		if (!exp_err) begin
			for (int b = 0; b < nbytes; b++) begin
				pos = POS_W'(off + 32'(b));
				if (store) begin
					shadow[pos] = wdata[8*b +: 8];
				end else begin
					val[8*b +: 8] = shadow[pos];
				end
			end
			// signed loads copy the top loaded bit upward
			if ((op == LB || op == LH) && val[8*nbytes-1]) begin
				val = val | (32'hffff_ffff << (8 * nbytes));
			end
			if (!store) begin
				exp_data = val;
			end
		end
	endtask

	// one request, then wait for its completion
	task automatic run_req(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
		logic [REG_W-1:0] rd;
		rd = REG_W'(rand_bits(REG_W));
		predict(op, addr, wdata);
		exp_rd    = rd;
		req_op    = op;
		req_addr  = addr;
		req_wdata = wdata;
		req_rd    = rd;
		req_valid = 1'b1;
		while (!req_ready) begin
			@(posedge clock);
			#1;
		end
		@(posedge clock);
		#1;
		req_valid = 1'b0;
		accepted++;
		while (responded != accepted) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic word_test();
		logic [31:0] addrs [N_WORDS];
		for (int i = 0; i < N_WORDS; i++) begin
			addrs[i] = BASE_ADDR + (rand_bits(8) << 2);
			run_req(SW, addrs[i], rand_bits(32));
		end
		for (int i = 0; i < N_WORDS; i++) begin
			run_req(LW, addrs[i], '0);
		end
	endtask

	// sb covers lane w, sh alternates halves
	task automatic lane_test();
		logic [31:0] addr;
		for (int w = 0; w < N_LANE; w++) begin
			addr = BASE_ADDR + (rand_bits(8) << 2);
			run_req(SW, addr, rand_bits(32) | 32'h8080_8080);
			run_req(SB, addr + 32'(w), rand_bits(32));
			run_req(LW, addr, '0);
			run_req(SH, addr + 32'(2 * (w % 2)), rand_bits(32));
			run_req(LW, addr, '0);
			for (int lane = 0; lane < 4; lane++) begin
				run_req(LB, addr + 32'(lane), '0);
				run_req(LBU, addr + 32'(lane), '0);
			end
			for (int half = 0; half < 4; half += 2) begin
				run_req(LH, addr + 32'(half), '0);
				run_req(LHU, addr + 32'(half), '0);
			end
		end
	endtask

	task automatic misalign_test();
		logic [31:0] addr;
		addr = BASE_ADDR + (rand_bits(8) << 2);
		run_req(SW, addr, rand_bits(32));
		for (int off = 1; off < 4; off++) begin
			run_req(LW, addr + 32'(off), '0);
			run_req(SW, addr + 32'(off), rand_bits(32));
		end
		for (int off = 1; off < 4; off += 2) begin
			run_req(LH, addr + 32'(off), '0);
			run_req(SH, addr + 32'(off), rand_bits(32));
		end
		// refused stores left the word alone
		run_req(LW, addr, '0);
	endtask

	// out of range address aliases an in range word in the low index bits
	task automatic range_test();
		logic [31:0] in_addr;
		logic [31:0] out_addr;
		for (int k = 0; k < N_OOR; k++) begin
			in_addr  = BASE_ADDR + (rand_bits(8) << 2);
			out_addr = in_addr + MEM_BYTES;
			run_req(SW, in_addr, rand_bits(32));
			run_req(SW, out_addr, rand_bits(32));
			run_req(LW, out_addr, '0);
			run_req(LB, out_addr + 32'(k), '0);
			run_req(LW, in_addr, '0);
		end
	endtask

	initial begin
		rstn      = 1'b0;
		req_valid = 1'b0;
		req_op    = LB;
		req_addr  = '0;
		req_wdata = '0;
		req_rd    = '0;
		exp_data  = '0;
		exp_rd    = '0;
		exp_err   = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		rstn = 1'b1;
		@(posedge clock);
		#1;
		word_test();
		lane_test();
		misalign_test();
		range_test();
		repeat (2) @(posedge clock);
		#1;
		$display("errors: data %0d rd %0d err_flag %0d protocol %0d, %0d requests",
			data_errs, rd_errs, flag_errs, proto_errs, accepted);
		if (data_errs + rd_errs + flag_errs + proto_errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
axi_pkg.sv
lsu_pkg.sv
lsu_align.sv
lsu_ctrl.sv
axi_sram.sv
lsu_top.sv
tb_lsu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_lsu_top
FILELIST  := sources.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
PASS_MSG  := Simulation completed successfully
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
